// File: hdl/rv_exec_consts.svh
`ifndef RV_EXEC_CONSTS_SVH
`define RV_EXEC_CONSTS_SVH

// data path and register number widths
`define XLEN        32
`define REG_AW      5

`define RESET_PC    32'h0000_0000

// major opcodes of the supported instruction classes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111

`endif

// File: hdl/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    // alu function, PASS_B carries the LUI immediate through
    typedef enum logic [3:0]
    {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B
    } alu_op_t;

    typedef enum logic {REG, IMM} op2_src_t;

    typedef enum logic [1:0] {BP_REG, BP_EX, BP_WB} bypass_sel_t;

    typedef enum logic {IDLE, BUS} fetch_state_t;

endpackage

`default_nettype wire

// File: hdl/wb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module wb_fetch
    import rv_exec_pkg::*;
(
    input   wire                    i_clk,
    input   wire                    i_reset,
    input   wire                    i_wb_ack,
    input   wire[31:0]              i_wb_dat,
    output  logic                   o_wb_cyc,
    output  logic                   o_wb_stb,
    output  logic[31:0]             o_wb_adr,
    output  logic                   o_inst_valid,
    output  logic[31:0]             o_inst
);

    fetch_state_t       state;
    logic[`XLEN-1:0]    pc;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state <= IDLE;
            pc <= `RESET_PC;
        end
        else
        begin
            case (state)
            IDLE:
                state <= BUS;           // one dead cycle between read cycles
            BUS:
                if (i_wb_ack)
                begin
                    state <= IDLE;
                    pc <= pc + `XLEN'd4;
                end
            default:
                state <= IDLE;
            endcase
        end
    end

    assign o_wb_cyc = (state == BUS);
    assign o_wb_stb = (state == BUS);
    assign o_wb_adr = pc;

    // the word is handed to decode in the same cycle as the ack
    assign o_inst_valid = o_wb_stb & i_wb_ack;
    assign o_inst = i_wb_dat;

    // a pending request holds its address until the slave answers
    a_adr_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_wb_stb && !i_wb_ack) |=> (o_wb_stb && $stable(o_wb_adr)));

endmodule

`default_nettype wire

// File: hdl/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module rv_decode
    import rv_exec_pkg::*;
(
    input   wire                    i_clk,
    input   wire                    i_reset,
    input   wire                    i_inst_valid,
    input   wire[31:0]              i_inst,
    output  logic                   o_valid,
    output  logic[`REG_AW-1:0]      o_rs1,
    output  logic[`REG_AW-1:0]      o_rs2,
    output  logic[`REG_AW-1:0]      o_rd,
    output  logic                   o_reg_write,
    output  alu_op_t                o_alu_op,
    output  op2_src_t               o_op2_src,
    output  logic[`XLEN-1:0]        o_imm
);

    logic           inst_valid;
    logic[31:0]     inst;
    logic           known;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            inst_valid <= 1'b0;
        else
            inst_valid <= i_inst_valid;     // no ack means a bubble
        inst <= i_inst;
    end

    // funct3 mapping shared by OP and OP-IMM, alt picks SUB or SRA
    function automatic alu_op_t f3_to_op(input logic [2:0] f3, input logic alt);
        case (f3)
        3'b000:  return alt ? SUB : ADD;
        3'b001:  return SLL;
        3'b010:  return SLT;
        3'b011:  return SLTU;
        3'b100:  return XOR;
        3'b101:  return alt ? SRA : SRL;
        3'b110:  return OR;
        default: return AND;
        endcase
    endfunction

    always_comb
    begin
        known = 1'b1;
        o_op2_src = IMM;
        o_alu_op = ADD;
        o_imm = {{20{inst[31]}}, inst[31:20]};
        o_rs1 = inst[19:15];
        case (inst[6:0])
        `OPC_OP:
        begin
            o_op2_src = REG;
            o_alu_op = f3_to_op(inst[14:12], inst[30]);
        end
        `OPC_OP_IMM:
            o_alu_op = f3_to_op(inst[14:12], inst[30] & (inst[14:12] == 3'b101));
        `OPC_LUI:
        begin
            o_alu_op = PASS_B;
            o_imm = {inst[31:12], 12'b0};
            o_rs1 = '0;     // keeps a stale rs1 field from pulling a bypass
        end
        default:
            known = 1'b0;
        endcase
    end

    assign o_valid = inst_valid & known;
    assign o_reg_write = inst_valid & known;
    assign o_rs2 = inst[24:20];
    assign o_rd = inst[11:7];

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module reg_file
(
    input   wire                    i_clk,
    input   wire                    i_reset,
    input   wire                    i_we,
    input   wire[`REG_AW-1:0]       i_wr_addr,
    input   wire[`XLEN-1:0]         i_wr_data,
    input   wire[`REG_AW-1:0]       i_rd_addr1,
    input   wire[`REG_AW-1:0]       i_rd_addr2,
    output  logic[`XLEN-1:0]        o_rd_data1,
    output  logic[`XLEN-1:0]        o_rd_data2
);

    logic[`XLEN-1:0]    regs[1:31];
    logic               wr_live;

    assign wr_live = i_we & (i_wr_addr != '0);     // x0 writes are dropped

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_live)
            regs[i_wr_addr] <= i_wr_data;
    end

    // write-through covers the instruction three ahead
    always_comb
    begin
        if (i_rd_addr1 == '0)
            o_rd_data1 = '0;
        else if (wr_live && i_wr_addr == i_rd_addr1)
            o_rd_data1 = i_wr_data;
        else
            o_rd_data1 = regs[i_rd_addr1];
    end

    always_comb
    begin
        if (i_rd_addr2 == '0)
            o_rd_data2 = '0;
        else if (wr_live && i_wr_addr == i_rd_addr2)
            o_rd_data2 = i_wr_data;
        else
            o_rd_data2 = regs[i_rd_addr2];
    end

endmodule

`default_nettype wire

// File: hdl/ex_operand.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module ex_operand
    import rv_exec_pkg::*;
(
    input   wire                    i_clk,
    input   wire                    i_reset,
    input   wire                    i_valid,
    input   wire[`REG_AW-1:0]       i_rd,
    input   wire                    i_reg_write,
    input   wire alu_op_t           i_alu_op,
    input   wire op2_src_t          i_op2_src,
    input   wire[`XLEN-1:0]         i_imm,
    input   wire[`XLEN-1:0]         i_reg1_data,
    input   wire[`XLEN-1:0]         i_reg2_data,
    input   wire bypass_sel_t       i_rs1_bp,
    input   wire bypass_sel_t       i_rs2_bp,
    input   wire[`XLEN-1:0]         i_ex_data,
    input   wire[`XLEN-1:0]         i_wb_data,
    output  logic                   o_valid,
    output  logic[`REG_AW-1:0]      o_rd,
    output  logic                   o_reg_write,
    output  alu_op_t                o_alu_op,
    output  logic[`XLEN-1:0]        o_op1,
    output  logic[`XLEN-1:0]        o_op2
);

    op2_src_t           op2_src;
    logic[`XLEN-1:0]    imm;
    logic[`XLEN-1:0]    reg1_data;
    logic[`XLEN-1:0]    reg2_data;
    logic[`XLEN-1:0]    bp1;
    logic[`XLEN-1:0]    bp2;

    // ******************************************************************
    // pipeline register after decode

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_valid <= 1'b0;
            o_reg_write <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
            o_reg_write <= i_reg_write;
        end
        o_rd <= i_rd;
        o_alu_op <= i_alu_op;
        op2_src <= i_op2_src;
        imm <= i_imm;
        reg1_data <= i_reg1_data;   // read in D, may already be stale here
        reg2_data <= i_reg2_data;
    end

    // ******************************************************************
    // bypass and operand select

    function automatic logic [`XLEN-1:0] bypass(input bypass_sel_t sel,
                                                input logic [`XLEN-1:0] reg_data,
                                                input logic [`XLEN-1:0] ex_data,
                                                input logic [`XLEN-1:0] wb_data);
        case (sel)
        BP_EX:   return ex_data;
        BP_WB:   return wb_data;
        default: return reg_data;
        endcase
    endfunction

    assign bp1 = bypass(i_rs1_bp, reg1_data, i_ex_data, i_wb_data);
    assign bp2 = bypass(i_rs2_bp, reg2_data, i_ex_data, i_wb_data);

    assign o_op1 = bp1;
    assign o_op2 = (op2_src == IMM) ? imm : bp2;

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module alu
    import rv_exec_pkg::*;
(
    input   wire                    i_clk,
    input   wire                    i_reset,
    input   wire                    i_valid,
    input   wire[`REG_AW-1:0]       i_rd,
    input   wire                    i_reg_write,
    input   wire alu_op_t           i_alu_op,
    input   wire[`XLEN-1:0]         i_op1,
    input   wire[`XLEN-1:0]         i_op2,
    output  logic                   o_ex_valid,
    output  logic[`REG_AW-1:0]      o_ex_rd,
    output  logic                   o_ex_write,
    output  logic[`XLEN-1:0]        o_ex_data,
    output  logic                   o_wb_valid,
    output  logic[`REG_AW-1:0]      o_wb_rd,
    output  logic                   o_wb_write,
    output  logic[`XLEN-1:0]        o_wb_data
);

    logic[4:0]          shamt;
    logic[`XLEN-1:0]    result;

    assign shamt = i_op2[4:0];

    always_comb
    begin
        case (i_alu_op)
        ADD:     result = i_op1 + i_op2;
        SUB:     result = i_op1 - i_op2;
        SLL:     result = i_op1 << shamt;
        SLT:     result = {31'b0, $signed(i_op1) < $signed(i_op2)};
        SLTU:    result = {31'b0, i_op1 < i_op2};
        XOR:     result = i_op1 ^ i_op2;
        SRL:     result = i_op1 >> shamt;
        SRA:     result = $signed(i_op1) >>> shamt;
        OR:      result = i_op1 | i_op2;
        AND:     result = i_op1 & i_op2;
        default: result = i_op2;    // PASS_B
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_ex_valid <= 1'b0;
            o_ex_write <= 1'b0;
            o_wb_valid <= 1'b0;
            o_wb_write <= 1'b0;
        end
        else
        begin
            o_ex_valid <= i_valid;
            o_ex_write <= i_reg_write;
            o_wb_valid <= o_ex_valid;   // W is X one cycle later
            o_wb_write <= o_ex_write;
        end
        o_ex_rd <= i_rd;
        o_ex_data <= result;
        o_wb_rd <= o_ex_rd;
        o_wb_data <= o_ex_data;
    end

endmodule

`default_nettype wire

// File: hdl/hazard_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module hazard_ctrl
    import rv_exec_pkg::*;
(
    input   wire[`REG_AW-1:0]       i_dec_rs1,
    input   wire[`REG_AW-1:0]       i_dec_rs2,
    input   wire                    i_ex_valid,
    input   wire[`REG_AW-1:0]       i_ex_rd,
    input   wire                    i_ex_write,
    input   wire                    i_wb_valid,
    input   wire[`REG_AW-1:0]       i_wb_rd,
    input   wire                    i_wb_write,
    input   wire                    i_clk,
    input   wire                    i_reset,
    output  bypass_sel_t            o_rs1_bp,
    output  bypass_sel_t            o_rs2_bp
);

    logic[`REG_AW-1:0]  op_rs1;
    logic[`REG_AW-1:0]  op_rs2;
    logic               ex_fwd;
    logic               wb_fwd;

    // source numbers of the instruction now in O
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            op_rs1 <= '0;
            op_rs2 <= '0;
        end
        else
        begin
            op_rs1 <= i_dec_rs1;
            op_rs2 <= i_dec_rs2;
        end
    end

    assign ex_fwd = i_ex_valid & i_ex_write & (i_ex_rd != '0);
    assign wb_fwd = i_wb_valid & i_wb_write & (i_wb_rd != '0);

    // the younger result in X wins over W
    function automatic bypass_sel_t pick(input logic [`REG_AW-1:0] rs,
                                         input logic ex_hit,
                                         input logic wb_hit);
        if (ex_hit && rs == i_ex_rd)
            return BP_EX;
        else if (wb_hit && rs == i_wb_rd)
            return BP_WB;
        return BP_REG;
    endfunction

    assign o_rs1_bp = pick(op_rs1, ex_fwd, wb_fwd);
    assign o_rs2_bp = pick(op_rs2, ex_fwd, wb_fwd);

    // a stage only marks a register write while it holds an instruction
    a_ex_write_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        i_ex_write |-> i_ex_valid);

    a_wb_write_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wb_write |-> i_wb_valid);

endmodule

`default_nettype wire

// File: hdl/rv_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module rv_exec_top
    import rv_exec_pkg::*;
(
    input   wire                    i_clk,
    input   wire                    i_reset,
    input   wire                    i_wb_ack,
    input   wire[31:0]              i_wb_dat,
    output  logic                   o_wb_cyc,
    output  logic                   o_wb_stb,
    output  logic[31:0]             o_wb_adr,
    output  logic                   o_ret_valid,
    output  logic[`REG_AW-1:0]      o_ret_rd,
    output  logic[`XLEN-1:0]        o_ret_data
);

    logic                   inst_valid;
    logic[31:0]             inst;
    logic                   dec_valid;
    logic[`REG_AW-1:0]      dec_rs1;
    logic[`REG_AW-1:0]      dec_rs2;
    logic[`REG_AW-1:0]      dec_rd;
    logic                   dec_reg_write;
    alu_op_t                dec_alu_op;
    op2_src_t               dec_op2_src;
    logic[`XLEN-1:0]        dec_imm;
    logic[`XLEN-1:0]        reg1_data;
    logic[`XLEN-1:0]        reg2_data;
    bypass_sel_t            rs1_bp;
    bypass_sel_t            rs2_bp;
    logic                   op_valid;
    logic[`REG_AW-1:0]      op_rd;
    logic                   op_reg_write;
    alu_op_t                op_alu_op;
    logic[`XLEN-1:0]        op1;
    logic[`XLEN-1:0]        op2;
    logic                   ex_valid;
    logic[`REG_AW-1:0]      ex_rd;
    logic                   ex_write;
    logic[`XLEN-1:0]        ex_data;
    logic                   wb_valid;
    logic[`REG_AW-1:0]      wb_rd;
    logic                   wb_write;
    logic[`XLEN-1:0]        wb_data;

    wb_fetch u_fetch (.i_clk, .i_reset, .i_wb_ack, .i_wb_dat, .o_wb_cyc, .o_wb_stb,
        .o_wb_adr, .o_inst_valid(inst_valid), .o_inst(inst));

    rv_decode u_decode (.i_clk, .i_reset, .i_inst_valid(inst_valid), .i_inst(inst),
        .o_valid(dec_valid), .o_rs1(dec_rs1), .o_rs2(dec_rs2), .o_rd(dec_rd),
        .o_reg_write(dec_reg_write), .o_alu_op(dec_alu_op), .o_op2_src(dec_op2_src),
        .o_imm(dec_imm));

    reg_file u_regs (.i_clk, .i_reset, .i_we(wb_valid & wb_write), .i_wr_addr(wb_rd),
        .i_wr_data(wb_data), .i_rd_addr1(dec_rs1), .i_rd_addr2(dec_rs2),
        .o_rd_data1(reg1_data), .o_rd_data2(reg2_data));

    ex_operand u_operand (.i_clk, .i_reset, .i_valid(dec_valid), .i_rd(dec_rd),
        .i_reg_write(dec_reg_write), .i_alu_op(dec_alu_op), .i_op2_src(dec_op2_src),
        .i_imm(dec_imm), .i_reg1_data(reg1_data), .i_reg2_data(reg2_data),
        .i_rs1_bp(rs1_bp), .i_rs2_bp(rs2_bp), .i_ex_data(ex_data), .i_wb_data(wb_data),
        .o_valid(op_valid), .o_rd(op_rd), .o_reg_write(op_reg_write),
        .o_alu_op(op_alu_op), .o_op1(op1), .o_op2(op2));

    alu u_alu (.i_clk, .i_reset, .i_valid(op_valid), .i_rd(op_rd),
        .i_reg_write(op_reg_write), .i_alu_op(op_alu_op), .i_op1(op1), .i_op2(op2),
        .o_ex_valid(ex_valid), .o_ex_rd(ex_rd), .o_ex_write(ex_write), .o_ex_data(ex_data),
        .o_wb_valid(wb_valid), .o_wb_rd(wb_rd), .o_wb_write(wb_write), .o_wb_data(wb_data));

    hazard_ctrl u_hazard (.i_dec_rs1(dec_rs1), .i_dec_rs2(dec_rs2), .i_ex_valid(ex_valid),
        .i_ex_rd(ex_rd), .i_ex_write(ex_write), .i_wb_valid(wb_valid), .i_wb_rd(wb_rd),
        .i_wb_write(wb_write), .i_clk, .i_reset, .o_rs1_bp(rs1_bp), .o_rs2_bp(rs2_bp));

    // x0 destinations never show up on the retire port
    assign o_ret_valid = wb_valid & wb_write & (wb_rd != '0);
    assign o_ret_rd = wb_rd;
    assign o_ret_data = wb_data;

endmodule

`default_nettype wire

// File: dv/rv_exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module rv_exec_tb;

    localparam int N_PROG = 200;
    localparam int MEM_WORDS = 1024;
    localparam int TIMEOUT_CYCLES = N_PROG * (4 + 2) + 50;   // worst fetch is 3 waits plus 3

    logic           clk = 1'b0;
    logic           reset = 1'b1;
    logic           wb_ack = 1'b0;
    logic[31:0]     wb_dat = 32'd0;
    logic           wb_cyc;
    logic           wb_stb;
    logic[31:0]     wb_adr;
    logic           ret_valid;
    logic[4:0]      ret_rd;
    logic[31:0]     ret_data;

    logic[31:0]     mem[0:MEM_WORDS-1];
    logic[1:0]      wait_len[0:MEM_WORDS-1];
    logic[1:0]      wait_cnt = 2'd0;
    logic[15:0]     lfsr;
    logic[4:0]      recent_rd[0:3];
    logic[31:0]     model_regs[0:31];
    logic[4:0]      exp_rd[$];
    logic[31:0]     exp_data[$];

    int             ret_idx = 0;
    int             value_errs = 0;
    int             order_errs = 0;
    int             bus_errs = 0;
    int             end_errs = 0;
    int             bus_cycle = 0;
    logic           prev_stb = 1'b0;
    logic           prev_ack = 1'b0;
    logic[31:0]     prev_adr = 32'd0;
    logic[31:0]     next_adr = `RESET_PC;

    rv_exec_top u_dut (.i_clk(clk), .i_reset(reset), .i_wb_ack(wb_ack), .i_wb_dat(wb_dat),
        .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_adr(wb_adr), .o_ret_valid(ret_valid),
        .o_ret_rd(ret_rd), .o_ret_data(ret_data));

    initial
    begin
        forever #50 clk = ~clk;
    end

    // ******************************************************************
    // random source, x^16 + x^14 + x^13 + x^11 + 1

    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    // half the sources reuse one of the last four destinations
    function automatic logic [4:0] pick_src();
        logic [31:0] r;
        r = rand_bits(1);
        if (r[0])
        begin
            r = rand_bits(2);
            return recent_rd[r[1:0]];
        end
        r = rand_bits(3);
        return {2'b00, r[2:0]};
    endfunction

    // ******************************************************************
    // program image and reference model

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] word;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [1:0]  cls;
        logic        alt;
        for (int k = 0; k < 4; k++)
            recent_rd[k] = 5'd0;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            r = rand_bits(2);
            wait_len[i] = r[1:0];
            mem[i] = {2'b00, i[9:0], 5'd0, 3'b000, 5'd0, `OPC_OP_IMM};  // addi x0, x0, index
        end
        for (int i = 0; i < N_PROG; i++)
        begin
            r = rand_bits(3);
            rd = {2'b00, r[2:0]};               // x0..x7 keeps reuse and x0 writes frequent
            rs1 = pick_src();
            rs2 = pick_src();
            r = rand_bits(3);
            f3 = r[2:0];
            r = rand_bits(2);
            cls = r[1:0];
            case (cls)
            2'd2:
            begin
                r = rand_bits(6);
                if (f3 == 3'b001)
                    imm = {7'b0000000, r[4:0]};
                else if (f3 == 3'b101)
                    imm = {1'b0, r[5], 5'b00000, r[4:0]};
                else
                begin
                    r = rand_bits(12);
                    imm = r[11:0];
                end
                word = {imm, rs1, f3, rd, `OPC_OP_IMM};
            end
            2'd3:
            begin
                r = rand_bits(20);
                word = {r[19:0], rd, `OPC_LUI};
            end
            default:
            begin
                r = rand_bits(1);
                alt = r[0] & (f3 == 3'b000 || f3 == 3'b101);
                word = {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, `OPC_OP};
            end
            endcase
            mem[i] = word;
            recent_rd[3] = recent_rd[2];
            recent_rd[2] = recent_rd[1];
            recent_rd[1] = recent_rd[0];
            recent_rd[0] = rd;
        end
    endtask

    // one instruction as the ISA defines it, against the model registers
    function automatic logic [31:0] ref_result(input logic [31:0] inst);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic        is_op;
        is_op = (inst[6:0] == `OPC_OP);
        a = model_regs[inst[19:15]];
        b = is_op ? model_regs[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
        sh = b[4:0];
        if (inst[6:0] == `OPC_LUI)
            return {inst[31:12], 12'h000};
        case (inst[14:12])
        3'b000:  return (is_op && inst[30]) ? a - b : a + b;
        3'b001:  return a << sh;
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:
            if (inst[30])
                return $signed(a) >>> sh;
            else
                return a >> sh;
        3'b110:  return a | b;
        default: return a & b;
        endcase
    endfunction

    task automatic run_reference();
        logic [31:0] res;
        for (int k = 0; k < 32; k++)
            model_regs[k] = 32'd0;
        for (int i = 0; i < N_PROG; i++)
        begin
            res = ref_result(mem[i]);
            if (mem[i][11:7] != 5'd0)
            begin
                model_regs[mem[i][11:7]] = res;
                exp_rd.push_back(mem[i][11:7]);
                exp_data.push_back(res);
            end
        end
    endtask

    task automatic print_counts();
        $display("errors %0d: value %0d, order %0d, bus %0d, end %0d; retired %0d of %0d",
                 value_errs + order_errs + bus_errs + end_errs, value_errs, order_errs,
                 bus_errs, end_errs, ret_idx, exp_rd.size());
    endtask

    // ******************************************************************
    // Wishbone memory, acks after 0 to 3 extra cycles

    always @(posedge clk)
    begin
        if (reset)
        begin
            wb_ack <= 1'b0;
            wait_cnt <= 2'd0;
        end
        else if (wb_ack)
        begin
            wb_ack <= 1'b0;             // single cycle ack
            wait_cnt <= 2'd0;
        end
        else if (wb_stb)
        begin
            if (wait_cnt == wait_len[wb_adr[11:2]])
            begin
                wb_ack <= 1'b1;
                wb_dat <= mem[wb_adr[11:2]];
            end
            else
                wait_cnt <= wait_cnt + 2'd1;
        end
    end

    always @(posedge clk)
    begin
        bus_cycle++;
        // samples of the reset cycle and the one after it
        if (bus_cycle == 2 || bus_cycle == 3)
        begin
            assert (!wb_cyc && !wb_stb && !ret_valid)
            else
            begin
                $display("t=%0t bus or retire active during or just after reset", $time);
                bus_errs++;
            end
        end
        if (bus_cycle >= 2)
        begin
            assert (wb_cyc == wb_stb)
            else
            begin
                $display("t=%0t cyc and stb are not driven together", $time);
                bus_errs++;
            end
            if (prev_stb && !prev_ack)
            begin
                assert (wb_stb && wb_adr == prev_adr)
                else
                begin
                    $display("t=%0t request at %h dropped or moved before ack", $time, prev_adr);
                    bus_errs++;
                end
            end
            if (prev_stb && prev_ack)
            begin
                assert (!wb_stb)
                else
                begin
                    $display("t=%0t stb did not drop for a cycle after ack", $time);
                    bus_errs++;
                end
            end
            if (wb_stb && !prev_stb)
            begin
                assert (wb_adr == next_adr)
                else
                begin
                    $display("MISMATCH t=%0t o_wb_adr got %h expected %h", $time, wb_adr,
                             next_adr);
                    bus_errs++;
                end
            end
            if (wb_stb && wb_ack)
                next_adr = next_adr + 32'd4;
            prev_stb = wb_stb;
            prev_ack = wb_ack;
            prev_adr = wb_adr;
        end
    end

    // ******************************************************************
    // retire checker

    always @(posedge clk)
    begin
        if (!reset && ret_valid)
        begin
            assert (ret_idx < exp_rd.size())
            else
            begin
                $display("t=%0t retire of x%0d with nothing left to retire", $time, ret_rd);
                order_errs++;
            end
            if (ret_idx < exp_rd.size())
            begin
                assert (ret_rd == exp_rd[ret_idx])
                else
                begin
                    $display("MISMATCH t=%0t o_ret_rd got %0d expected %0d", $time, ret_rd,
                             exp_rd[ret_idx]);
                    value_errs++;
                end
                assert (ret_data == exp_data[ret_idx])
                else
                begin
                    $display("MISMATCH t=%0t o_ret_data got %h expected %h", $time, ret_data,
                             exp_data[ret_idx]);
                    value_errs++;
                end
            end
            ret_idx <= ret_idx + 1;
        end
    end

    initial
    begin : watchdog
        int cnt;
        cnt = 0;
        while (cnt < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cnt++;
        end
        $display("timeout after %0d cycles with retires still missing", cnt);
        print_counts();
        $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin
        lfsr = 16'd9990;
        build_program();
        run_reference();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        while (ret_idx < exp_rd.size())
            @(posedge clk);
        repeat (8) @(posedge clk);      // the NOP tail must stay silent
        assert (ret_idx == exp_rd.size())
        else
        begin
            $display("%0d instructions retired but %0d expected", ret_idx, exp_rd.size());
            end_errs++;
        end
        print_counts();
        if (value_errs + order_errs + bus_errs + end_errs == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_exec_top.f
+incdir+hdl
hdl/rv_exec_pkg.sv
hdl/wb_fetch.sv
hdl/rv_decode.sv
hdl/reg_file.sv
hdl/ex_operand.sv
hdl/alu.sv
hdl/hazard_ctrl.sv
hdl/rv_exec_top.sv
dv/rv_exec_tb.sv

// File: run.sh
#!/bin/sh
# build and run the rv_exec testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module rv_exec_tb -f rv_exec_top.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vrv_exec_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
    exit 0
fi
echo "pass message not found"
exit 1
